// File: hw/nand_pkg.sv
package nand_pkg;

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////

  typedef logic [15:0] host_cmd_t;

  localparam host_cmd_t HOST_PAGE_READ = 16'h0030;
  localparam host_cmd_t HOST_STATUS    = 16'h7000;
  localparam host_cmd_t HOST_ERASE     = 16'h60D0;
  localparam host_cmd_t HOST_PROGRAM   = 16'h8010;
  localparam host_cmd_t HOST_RESET     = 16'hFF00;
  localparam logic [7:0] HOST_ID_PREFIX = 8'h90;  // low byte is don't care

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RESET,
    OP_STATUS,
    OP_READ_ID,
    OP_ERASE,
    OP_PROGRAM,
    OP_PAGE_READ
  } nand_op_e;

  typedef struct packed {
    nand_op_e op;
    logic     id_long;  // six ID bytes instead of four
  } op_req_t;

  ////////////////////////////////////////
  // flash side
  ////////////////////////////////////////

  localparam logic [7:0] FC_READ1   = 8'h00;
  localparam logic [7:0] FC_READ2   = 8'h30;
  localparam logic [7:0] FC_ERASE1  = 8'h60;
  localparam logic [7:0] FC_ERASE2  = 8'hD0;
  localparam logic [7:0] FC_PROG1   = 8'h80;
  localparam logic [7:0] FC_PROG2   = 8'h10;
  localparam logic [7:0] FC_STATUS  = 8'h70;
  localparam logic [7:0] FC_READ_ID = 8'h90;
  localparam logic [7:0] FC_RESET   = 8'hFF;

  // cycle types understood by the timing controller
  typedef enum logic [2:0] {
    TG_CMD        = 3'd0,
    TG_ADDR       = 3'd1,
    TG_REG_READ   = 3'd2,
    TG_PAGE_READ  = 3'd5,
    TG_PAGE_WRITE = 3'd7
  } toggle_code_e;

  typedef enum logic [1:0] {
    CAD_HOST_DATA = 2'd0,
    CAD_ADDR      = 2'd2,
    CAD_CMD       = 2'd3
  } cad_sel_e;

  typedef enum logic [2:0] {
    AM_COL1 = 3'd0,
    AM_COL2 = 3'd1,
    AM_ROW1 = 3'd2,
    AM_ROW2 = 3'd3,
    AM_ROW3 = 3'd4
  } amux_sel_e;

  typedef struct packed {
    logic         en;
    toggle_code_e code;
    cad_sel_e     cad_sel;
    amux_sel_e    amux_sel;
    logic [7:0]   cmd;
    logic [11:0]  reg_addr;
  } toggle_req_t;

  typedef enum logic {W_TCLR, W_TWB} wait_kind_e;

  localparam logic [11:0] ID_REG_BASE     = 12'h500;  // 500..505
  localparam logic [11:0] STATUS_REG_ADDR = 12'h506;

endpackage

// File: hw/nand_op_decode.sv
`timescale 1ns/1ns

module nand_op_decode import nand_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  host_cmd_t command_i,
  input  logic      busy_i,
  output op_req_t   op_req_o,
  output logic      op_valid_o
);

  host_cmd_t cmd_q;
  logic      pend_q;  // a start was taken last cycle
  nand_op_e  dec_op;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= start_i && !busy_i;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && !busy_i) begin
      cmd_q <= command_i;
    end
  end

  always_comb begin
    dec_op = OP_NONE;
    case (cmd_q)
      HOST_RESET:     dec_op = OP_RESET;
      HOST_STATUS:    dec_op = OP_STATUS;
      HOST_ERASE:     dec_op = OP_ERASE;
      HOST_PROGRAM:   dec_op = OP_PROGRAM;
      HOST_PAGE_READ: dec_op = OP_PAGE_READ;
      default: begin
        if (cmd_q[15:8] == HOST_ID_PREFIX) begin
          dec_op = OP_READ_ID;
        end
      end
    endcase
  end

  assign op_req_o.op      = dec_op;
  assign op_req_o.id_long = cmd_q[5];  // 90 with bit 5 set wants 6 bytes

  // unknown words are dropped here
  assign op_valid_o = pend_q && (dec_op != OP_NONE);

endmodule

// File: hw/nand_wait_timer.sv
`timescale 1ns/1ns

module nand_wait_timer import nand_pkg::*; #(
  parameter int T_CLR_CYC = 4,
  parameter int T_WB_CYC  = 12,
  parameter int TIMER_W   = 8
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       wait_start_i,
  input  wait_kind_e wait_kind_i,
  output logic       wait_done_o
);

  logic               armed_q;
  logic [TIMER_W-1:0] cnt_q;
  logic [TIMER_W-1:0] target_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      armed_q <= 1'b0;
    end else if (wait_start_i) begin
      armed_q <= 1'b1;
    end
  end

  // count starts at 1 so done rises exactly N cycles after the pulse
  always_ff @(posedge clk) begin
    if (wait_start_i) begin
      cnt_q    <= TIMER_W'(1);
      target_q <= (wait_kind_i == W_TWB) ? TIMER_W'(T_WB_CYC) : TIMER_W'(T_CLR_CYC);
    end else if (armed_q && (cnt_q != target_q)) begin
      cnt_q <= cnt_q + TIMER_W'(1);
    end
  end

  // a level held until the next start
  assign wait_done_o = armed_q && (cnt_q == target_q);

endmodule

// File: hw/nand_op_sequencer.sv
`timescale 1ns/1ns

module nand_op_sequencer import nand_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  op_req_t     op_req_i,
  input  logic        op_valid_i,
  input  logic        page_width_i,
  input  logic        r_nb_i,
  input  logic        toggle_done_i,
  input  logic        wait_done_i,
  output logic        wait_start_o,
  output wait_kind_e  wait_kind_o,
  output toggle_req_t toggle_o,
  output logic        cmd_en_o,
  output logic        row_addr_en_o,
  output logic        col_addr_en_o,
  output logic        flash_read_o,
  output logic        flash_write_o,
  output logic        op_done_o,
  output logic        busy_o
);

  localparam logic [7:0] ID_ADDR_BYTE = 8'h00;  // single address cycle of read ID

  typedef enum logic [3:0] {
    S_IDLE,
    S_CMD_LATCH,   // byte onto cmd bus
    S_CMD,         // TG_CMD request
    S_ADDR,        // one address cycle per amux_q
    S_ID_LATCH,
    S_ID_ADDR,
    S_WAIT_START,
    S_WAIT_TMR,
    S_WAIT_RDY,
    S_DATA_WRITE,
    S_DATA_READ,
    S_REG_READ,
    S_DONE
  } seq_state_e;

  seq_state_e  state_q, state_d;
  nand_op_e    op_q, op_d;
  logic        id_long_q, id_long_d;
  logic [7:0]  cmd_q, cmd_d;          // command byte of the current phase
  amux_sel_e   amux_q, amux_d;
  logic [11:0] reg_addr_q, reg_addr_d;
  logic [11:0] id_last;

  assign id_last = ID_REG_BASE + (id_long_q ? 12'd5 : 12'd3);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q    <= S_IDLE;
      op_q       <= OP_NONE;
      id_long_q  <= 1'b0;
      cmd_q      <= 8'h00;
      amux_q     <= AM_COL1;
      reg_addr_q <= 12'h000;
    end else begin
      state_q    <= state_d;
      op_q       <= op_d;
      id_long_q  <= id_long_d;
      cmd_q      <= cmd_d;
      amux_q     <= amux_d;
      reg_addr_q <= reg_addr_d;
    end
  end

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    op_d       = op_q;
    id_long_d  = id_long_q;
    cmd_d      = cmd_q;
    amux_d     = amux_q;
    reg_addr_d = reg_addr_q;
    case (state_q)
      S_IDLE: begin
        if (op_valid_i) begin
          op_d      = op_req_i.op;
          id_long_d = op_req_i.id_long;
          state_d   = S_CMD_LATCH;
          amux_d    = AM_COL1;
          case (op_req_i.op)
            OP_RESET:     cmd_d = FC_RESET;
            OP_STATUS:    cmd_d = FC_STATUS;
            OP_READ_ID:   cmd_d = FC_READ_ID;
            OP_PROGRAM:   cmd_d = FC_PROG1;
            OP_PAGE_READ: cmd_d = FC_READ1;
            OP_ERASE: begin
              cmd_d  = FC_ERASE1;
              amux_d = AM_ROW1;  // erase has row cycles only
            end
            default: state_d = S_IDLE;
          endcase
        end
      end
      S_CMD_LATCH: state_d = S_CMD;
      S_CMD: begin
        if (toggle_done_i) begin
          case (cmd_q)
            FC_READ_ID: state_d = S_ID_LATCH;
            FC_READ1, FC_PROG1, FC_ERASE1: state_d = S_ADDR;
            FC_STATUS: begin
              state_d    = S_WAIT_START;
              reg_addr_d = STATUS_REG_ADDR;
            end
            default: state_d = S_WAIT_START;  // 30, D0, 10, FF
          endcase
        end
      end
      S_ADDR: begin
        if (toggle_done_i) begin
          case (amux_q)
            AM_COL1: amux_d = page_width_i ? AM_COL2 : AM_ROW1;
            AM_COL2: amux_d = AM_ROW1;
            AM_ROW1: amux_d = AM_ROW2;
            AM_ROW2: amux_d = AM_ROW3;
            default: begin
              // last row cycle, pick the next phase
              if (op_q == OP_PROGRAM) begin
                state_d = S_DATA_WRITE;
              end else begin
                state_d = S_CMD_LATCH;
                cmd_d   = (op_q == OP_ERASE) ? FC_ERASE2 : FC_READ2;
              end
            end
          endcase
        end
      end
      S_ID_LATCH: state_d = S_ID_ADDR;
      S_ID_ADDR: begin
        if (toggle_done_i) begin
          state_d    = S_REG_READ;
          reg_addr_d = ID_REG_BASE;
        end
      end
      S_WAIT_START: state_d = S_WAIT_TMR;
      S_WAIT_TMR: begin
        if (wait_done_i) begin
          state_d = (cmd_q == FC_STATUS) ? S_REG_READ : S_WAIT_RDY;
        end
      end
      S_WAIT_RDY: begin
        if (r_nb_i) begin
          case (cmd_q)
            FC_READ2: state_d = S_DATA_READ;
            FC_ERASE2, FC_PROG2: begin
              state_d = S_CMD_LATCH;  // chain into read status
              cmd_d   = FC_STATUS;
            end
            default: state_d = S_DONE;
          endcase
        end
      end
      S_DATA_WRITE: begin
        if (toggle_done_i) begin
          state_d = S_CMD_LATCH;
          cmd_d   = FC_PROG2;
        end
      end
      S_DATA_READ: begin
        if (toggle_done_i) begin
          state_d = S_DONE;
        end
      end
      S_REG_READ: begin
        if (toggle_done_i) begin
          if (cmd_q == FC_STATUS || reg_addr_q == id_last) begin
            state_d = S_DONE;
          end else begin
            reg_addr_d = reg_addr_q + 12'd1;
          end
        end
      end
      S_DONE: state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // per-state outputs
  ////////////////////////////////////////

  always_comb begin
    toggle_o          = '0;
    toggle_o.code     = TG_CMD;
    toggle_o.cad_sel  = CAD_CMD;
    toggle_o.amux_sel = amux_q;
    toggle_o.cmd      = cmd_q;
    toggle_o.reg_addr = reg_addr_q;
    cmd_en_o          = 1'b0;
    flash_read_o      = 1'b0;
    flash_write_o     = 1'b0;
    case (state_q)
      S_CMD_LATCH: cmd_en_o = 1'b1;
      S_CMD:       toggle_o.en = 1'b1;
      S_ADDR: begin
        toggle_o.en      = 1'b1;
        toggle_o.code    = TG_ADDR;
        toggle_o.cad_sel = CAD_ADDR;
      end
      S_ID_LATCH: begin
        cmd_en_o     = 1'b1;
        toggle_o.cmd = ID_ADDR_BYTE;
      end
      S_ID_ADDR: begin
        toggle_o.en   = 1'b1;
        toggle_o.code = TG_ADDR;  // 00 goes out on the cmd path
        toggle_o.cmd  = ID_ADDR_BYTE;
      end
      S_DATA_WRITE: begin
        toggle_o.en      = 1'b1;
        toggle_o.code    = TG_PAGE_WRITE;
        toggle_o.cad_sel = CAD_HOST_DATA;
        flash_write_o    = 1'b1;
      end
      S_DATA_READ: begin
        toggle_o.en   = 1'b1;
        toggle_o.code = TG_PAGE_READ;
        flash_read_o  = 1'b1;
      end
      S_REG_READ: begin
        toggle_o.en   = 1'b1;
        toggle_o.code = TG_REG_READ;
      end
      default: ;
    endcase
  end

  // address latches only on the first command of read, program, erase
  assign row_addr_en_o = (state_q == S_CMD_LATCH) &&
                         (cmd_q == FC_READ1 || cmd_q == FC_PROG1 || cmd_q == FC_ERASE1);
  assign col_addr_en_o = (state_q == S_CMD_LATCH) &&
                         (cmd_q == FC_READ1 || cmd_q == FC_PROG1);

  assign wait_start_o = (state_q == S_WAIT_START);
  assign wait_kind_o  = (cmd_q == FC_ERASE2 || cmd_q == FC_PROG2 || cmd_q == FC_RESET) ?
                        W_TWB : W_TCLR;

  assign op_done_o = (state_q == S_DONE);
  assign busy_o    = (state_q != S_IDLE) || op_valid_i;  // up with op_valid

endmodule

// File: hw/nand_flash_ctrl.sv
`timescale 1ns/1ns

module nand_flash_ctrl import nand_pkg::*; #(
  parameter int T_CLR_CYC = 4,
  parameter int T_WB_CYC  = 12,
  parameter int TIMER_W   = 8
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        start_i,
  input  host_cmd_t   command_i,
  input  logic        page_width_i,
  input  logic        r_nb_i,
  input  logic        toggle_done_i,
  output toggle_req_t toggle_o,
  output logic        cmd_en_o,
  output logic        row_addr_en_o,
  output logic        col_addr_en_o,
  output logic        flash_read_o,
  output logic        flash_write_o,
  output logic        op_done_o,
  output logic        busy_o
);

  op_req_t    op_req;
  logic       op_valid;
  logic       wait_start;
  wait_kind_e wait_kind;
  logic       wait_done;

  nand_op_decode nand_op_decode_inst (
    .clk        (clk),
    .rstn       (rstn),
    .start_i    (start_i),
    .command_i  (command_i),
    .busy_i     (busy_o),  // drops starts while an op runs
    .op_req_o   (op_req),
    .op_valid_o (op_valid)
  );

  nand_wait_timer #(
    .T_CLR_CYC (T_CLR_CYC),
    .T_WB_CYC  (T_WB_CYC),
    .TIMER_W   (TIMER_W)
  ) nand_wait_timer_inst (
    .clk          (clk),
    .rstn         (rstn),
    .wait_start_i (wait_start),
    .wait_kind_i  (wait_kind),
    .wait_done_o  (wait_done)
  );

  nand_op_sequencer nand_op_sequencer_inst (
    .clk           (clk),
    .rstn          (rstn),
    .op_req_i      (op_req),
    .op_valid_i    (op_valid),
    .page_width_i  (page_width_i),
    .r_nb_i        (r_nb_i),
    .toggle_done_i (toggle_done_i),
    .wait_done_i   (wait_done),
    .wait_start_o  (wait_start),
    .wait_kind_o   (wait_kind),
    .toggle_o      (toggle_o),
    .cmd_en_o      (cmd_en_o),
    .row_addr_en_o (row_addr_en_o),
    .col_addr_en_o (col_addr_en_o),
    .flash_read_o  (flash_read_o),
    .flash_write_o (flash_write_o),
    .op_done_o     (op_done_o),
    .busy_o        (busy_o)
  );

endmodule

// File: verif/nand_flash_ctrl_tb.sv
`timescale 1ns/1ns

module nand_flash_ctrl_tb import nand_pkg::*; ();

  localparam int T_CLR_CYC = 3;
  localparam int T_WB_CYC  = 6;
  localparam int TIMEOUT   = 300;  // cycles allowed per operation
  localparam int QUIET     = 20;   // idle window after each operation

  logic        clk = 1'b0;
  logic        rstn;
  logic        start_i;
  host_cmd_t   command_i;
  logic        page_width_i;
  logic        r_nb_i;
  logic        toggle_done_i;
  toggle_req_t toggle_o;
  logic        cmd_en_o, row_addr_en_o, col_addr_en_o;
  logic        flash_read_o, flash_write_o, op_done_o, busy_o;

  // completed requests and monitor counters kept by the model
  toggle_req_t log_q[$];
  logic        rd_q[$], wr_q[$];
  int n_cmd_en = 0, n_row_en = 0, n_col_en = 0, n_done = 0;
  int gap_viol = 0, rdy_viol = 0;
  int resp_wait = -1, busy_left = 0, gap_cnt = 0, gap_need = 0;
  logic gap_on = 1'b0;
  toggle_req_t s_req;
  logic s_done, s_rnb, s_rd, s_wr, s_latch, s_row, s_col, s_opdone;

  // expected list of the running test
  toggle_req_t exp_q[$];
  logic        exp_rd[$], exp_wr[$];
  int errors = 0, n_tests = 0, n_failed = 0, seed;

  always #4 clk = ~clk;

  nand_flash_ctrl #(
    .T_CLR_CYC (T_CLR_CYC),
    .T_WB_CYC  (T_WB_CYC),
    .TIMER_W   (8)
  ) nand_flash_ctrl_inst (
    .clk (clk), .rstn (rstn), .start_i (start_i), .command_i (command_i),
    .page_width_i (page_width_i), .r_nb_i (r_nb_i), .toggle_done_i (toggle_done_i),
    .toggle_o (toggle_o), .cmd_en_o (cmd_en_o), .row_addr_en_o (row_addr_en_o),
    .col_addr_en_o (col_addr_en_o), .flash_read_o (flash_read_o),
    .flash_write_o (flash_write_o), .op_done_o (op_done_o), .busy_o (busy_o)
  );

  ////////////////////////////////////////
  // timing controller and flash model
  ////////////////////////////////////////

  // keeps only the fields that matter for each cycle type
  function automatic toggle_req_t norm_req(toggle_req_t r);
    toggle_req_t n;
    n      = '0;
    n.en   = 1'b1;
    n.code = r.code;
    case (r.code)
      TG_CMD: begin
        n.cad_sel = r.cad_sel;
        n.cmd     = r.cmd;
      end
      TG_ADDR: begin
        n.cad_sel = r.cad_sel;
        if (r.cad_sel == CAD_ADDR) begin
          n.amux_sel = r.amux_sel;
        end else begin
          n.cmd = r.cmd;  // read ID address byte
        end
      end
      TG_REG_READ:   n.reg_addr = r.reg_addr;
      TG_PAGE_WRITE: n.cad_sel  = r.cad_sel;
      default: ;
    endcase
    return n;
  endfunction

  initial begin : tctrl_model
    seed          = $urandom(32'ha9d9);
    toggle_done_i = 1'b0;
    r_nb_i        = 1'b1;
    forever begin
      @(posedge clk);
      s_req    = toggle_o;
      s_done   = toggle_done_i;
      s_rnb    = r_nb_i;
      s_rd     = flash_read_o;
      s_wr     = flash_write_o;
      s_latch  = cmd_en_o;
      s_row    = row_addr_en_o;
      s_col    = col_addr_en_o;
      s_opdone = op_done_o;
      #1;
      toggle_done_i = 1'b0;
      if (s_latch) n_cmd_en++;
      if (s_row) n_row_en++;
      if (s_col) n_col_en++;
      if (s_opdone) n_done++;
      if (busy_left > 0) begin
        busy_left--;
        if (busy_left == 0) r_nb_i = 1'b1;  // flash ready again
      end
      if (s_req.en && !s_done) begin
        if (!s_rnb) rdy_viol++;
        if (gap_on) begin
          if (gap_cnt < gap_need) gap_viol++;
          gap_on = 1'b0;
        end
        if (resp_wait < 0) resp_wait = $urandom_range(3, 0);
        if (resp_wait == 0) begin
          toggle_done_i = 1'b1;
          log_q.push_back(norm_req(s_req));
          rd_q.push_back(s_rd);
          wr_q.push_back(s_wr);
          if (s_req.code == TG_CMD && (s_req.cmd == FC_READ2 || s_req.cmd == FC_ERASE2 ||
              s_req.cmd == FC_PROG2 || s_req.cmd == FC_STATUS)) begin
            gap_on   = 1'b1;
            gap_cnt  = 0;
            gap_need = (s_req.cmd == FC_ERASE2 || s_req.cmd == FC_PROG2) ?
                       T_WB_CYC + 1 : T_CLR_CYC + 1;
            if (s_req.cmd != FC_STATUS) begin
              r_nb_i    = 1'b0;  // confirm makes the flash busy
              busy_left = $urandom_range(T_WB_CYC + 10, 2);
            end
          end
        end
        resp_wait--;
      end else if (gap_on && !s_done) begin
        gap_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // checks and expected lists
  ////////////////////////////////////////

  task automatic check_req(input string name, input toggle_req_t exp, input toggle_req_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic push_exp(input toggle_req_t r, input logic rd, input logic wr);
    r.en = 1'b1;
    exp_q.push_back(r);
    exp_rd.push_back(rd);
    exp_wr.push_back(wr);
  endtask

  task automatic exp_cmd(input logic [7:0] b);
    toggle_req_t r;
    r         = '0;
    r.code    = TG_CMD;
    r.cad_sel = CAD_CMD;
    r.cmd     = b;
    push_exp(r, 1'b0, 1'b0);
  endtask

  task automatic exp_addr(input amux_sel_e am);
    toggle_req_t r;
    r          = '0;
    r.code     = TG_ADDR;
    r.cad_sel  = CAD_ADDR;
    r.amux_sel = am;
    push_exp(r, 1'b0, 1'b0);
  endtask

  task automatic exp_id_addr();
    toggle_req_t r;
    r         = '0;
    r.code    = TG_ADDR;
    r.cad_sel = CAD_CMD;  // 00 byte comes from the cmd path
    r.cmd     = 8'h00;
    push_exp(r, 1'b0, 1'b0);
  endtask

  task automatic exp_reg(input logic [11:0] addr);
    toggle_req_t r;
    r          = '0;
    r.code     = TG_REG_READ;
    r.reg_addr = addr;
    push_exp(r, 1'b0, 1'b0);
  endtask

  task automatic exp_page(input logic wr);
    toggle_req_t r;
    r         = '0;
    r.code    = wr ? TG_PAGE_WRITE : TG_PAGE_READ;
    r.cad_sel = CAD_HOST_DATA;
    push_exp(r, !wr, wr);
  endtask

  // column cycles by page width, then three row cycles
  task automatic exp_addr_cycles(input logic pw, input logic with_col);
    if (with_col) exp_addr(AM_COL1);
    if (with_col && pw) exp_addr(AM_COL2);
    exp_addr(AM_ROW1);
    exp_addr(AM_ROW2);
    exp_addr(AM_ROW3);
  endtask

  task automatic run_op(input string name, input host_cmd_t word, input logic pw,
                        input logic known, input logic poke, input int row_exp,
                        input int col_exp);
    int   base, t, i, lat0, row0, col0, done0, gap0, rdy0, lat_exp;
    logic done, busy_s;
    base  = log_q.size();
    lat0  = n_cmd_en;
    row0  = n_row_en;
    col0  = n_col_en;
    done0 = n_done;
    gap0  = gap_viol;
    rdy0  = rdy_viol;
    @(posedge clk);
    #1;
    command_i    = word;
    page_width_i = pw;
    start_i      = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    @(posedge clk);
    check_flag({name, " busy after start"}, known, busy_o);
    done   = 1'b0;
    busy_s = 1'b0;
    t      = 0;
    while (!done && t < TIMEOUT) begin
      @(posedge clk);
      done   = op_done_o;
      busy_s = busy_o;
      t++;
      #1;
      start_i = poke && (t == 4);  // second start while busy
      if (start_i) command_i = HOST_RESET;
    end
    if (known && !done) begin
      $display("%s: op_done did not arrive within %0d cycles", name, TIMEOUT);
      errors++;
    end
    if (known) check_flag({name, " busy at done"}, 1'b1, busy_s);
    else check_flag({name, " op_done"}, 1'b0, done);
    repeat (QUIET) @(posedge clk);
    check_count({name, " requests"}, exp_q.size(), log_q.size() - base);
    lat_exp = 0;
    for (i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].code == TG_CMD || (exp_q[i].code == TG_ADDR && exp_q[i].cad_sel == CAD_CMD))
        lat_exp++;
      if (base + i < log_q.size()) begin
        check_req($sformatf("%s req %0d", name, i), exp_q[i], log_q[base + i]);
        check_flag($sformatf("%s flash_read %0d", name, i), exp_rd[i], rd_q[base + i]);
        check_flag($sformatf("%s flash_write %0d", name, i), exp_wr[i], wr_q[base + i]);
      end
    end
    check_count({name, " cmd latches"}, lat_exp, n_cmd_en - lat0);
    check_count({name, " row latch"}, row_exp, n_row_en - row0);
    check_count({name, " col latch"}, col_exp, n_col_en - col0);
    check_count({name, " op_done pulses"}, known ? 1 : 0, n_done - done0);
    check_count({name, " early requests"}, 0, gap_viol - gap0);
    check_count({name, " requests while busy"}, 0, rdy_viol - rdy0);
    exp_q.delete();
    exp_rd.delete();
    exp_wr.delete();
  endtask

  task automatic report_test(input string name, input int err0);
    n_tests++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err0);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_status();
    int e0;
    e0 = errors;
    @(posedge clk);
    check_flag("idle outputs after reset", 1'b0, toggle_o.en | cmd_en_o | op_done_o | busy_o |
               flash_read_o | flash_write_o | row_addr_en_o | col_addr_en_o);
    exp_cmd(FC_RESET);
    run_op("reset", HOST_RESET, 1'b0, 1'b1, 1'b0, 0, 0);
    exp_cmd(FC_STATUS);
    exp_reg(STATUS_REG_ADDR);
    run_op("status", HOST_STATUS, 1'b0, 1'b1, 1'b0, 0, 0);
    report_test("reset_status", e0);
  endtask

  task automatic test_read_id();
    int e0, n;
    e0 = errors;
    for (int lng = 0; lng < 2; lng++) begin
      exp_cmd(FC_READ_ID);
      exp_id_addr();
      for (n = 0; n < (lng ? 6 : 4); n++) exp_reg(ID_REG_BASE + 12'(n));
      run_op(lng ? "read_id_6" : "read_id_4", lng ? 16'h9020 : 16'h9000,
             1'b0, 1'b1, 1'b0, 0, 0);
    end
    report_test("read_id", e0);
  endtask

  task automatic test_erase();
    int e0;
    e0 = errors;
    exp_cmd(FC_ERASE1);
    exp_addr_cycles(1'b0, 1'b0);  // rows only
    exp_cmd(FC_ERASE2);
    exp_cmd(FC_STATUS);
    exp_reg(STATUS_REG_ADDR);
    run_op("erase", HOST_ERASE, 1'b0, 1'b1, 1'b0, 1, 0);
    report_test("erase", e0);
  endtask

  task automatic test_program_read();
    int e0;
    e0 = errors;
    for (int pw = 0; pw < 2; pw++) begin
      exp_cmd(FC_PROG1);
      exp_addr_cycles(pw[0], 1'b1);
      exp_page(1'b1);
      exp_cmd(FC_PROG2);
      exp_cmd(FC_STATUS);
      exp_reg(STATUS_REG_ADDR);
      run_op($sformatf("program_w%0d", pw), HOST_PROGRAM, pw[0], 1'b1, 1'b0, 1, 1);
      exp_cmd(FC_READ1);
      exp_addr_cycles(pw[0], 1'b1);
      exp_cmd(FC_READ2);
      exp_page(1'b0);
      run_op($sformatf("page_read_w%0d", pw), HOST_PAGE_READ, pw[0], 1'b1, 1'b0, 1, 1);
    end
    report_test("program_read", e0);
  endtask

  task automatic test_unknown_busy();
    int e0;
    e0 = errors;
    run_op("unknown", 16'h1234, 1'b0, 1'b0, 1'b0, 0, 0);  // nothing expected
    exp_cmd(FC_STATUS);
    exp_reg(STATUS_REG_ADDR);
    run_op("start_while_busy", HOST_STATUS, 1'b0, 1'b1, 1'b1, 0, 0);
    report_test("unknown_busy", e0);
  endtask

  initial begin : main
    rstn         = 1'b0;
    start_i      = 1'b0;
    command_i    = '0;
    page_width_i = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    test_reset_status();
    test_read_id();
    test_erase();
    test_program_read();
    test_unknown_busy();
    $display("tests %0d, failed %0d, check errors %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/nand_pkg.sv
hw/nand_op_decode.sv
hw/nand_wait_timer.sv
hw/nand_op_sequencer.sv
hw/nand_flash_ctrl.sv
verif/nand_flash_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= nand_flash_ctrl_tb
RTL_TOP   ?= nand_flash_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RTL_SRCS  ?= hw/nand_pkg.sv hw/nand_op_decode.sv hw/nand_wait_timer.sv \
             hw/nand_op_sequencer.sv hw/nand_flash_ctrl.sv
TB_SRCS   ?= verif/nand_flash_ctrl_tb.sv
FAIL_MSG  := Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
